// File: design/limn_alu.sv
`timescale 1ns/100ps

module limn_alu (
    input  logic               clk,
    input  logic               rst,
    input  logic               alu_go,
    input  limn_pkg::alu_req_t alu_req,
    output limn_pkg::word_t    alu_result
);
    import limn_pkg::*;

    word_t a;
    word_t b_sh;      // Second operand after the shift
    word_t result_d;

    assign a = alu_req.a;

    // Shift applies to the register group only
    always_comb begin
        b_sh = alu_req.b;
        if (!alu_req.imm_mode) begin
            case (alu_req.shift_mode)
                LHS:      b_sh = alu_req.b >> alu_req.shift_amt;  // Right logical
                RHS:      b_sh = alu_req.b << alu_req.shift_amt;
                ASH, ROR: b_sh = $signed(alu_req.b) >>> alu_req.shift_amt;
            endcase
        end
    end

    always_comb begin
        case (alu_req.op)
            LUI_NOR: begin
                if (alu_req.imm_mode) begin
                    result_d = a | (b_sh << 16);
                end else begin
                    result_d = ~(a | b_sh);
                end
            end
            OR:      result_d = a | b_sh;
            XOR:     result_d = a ^ b_sh;
            AND:     result_d = a & b_sh;
            SLTS:    result_d = {31'h0, $signed(a) < $signed(b_sh)};
            SLT:     result_d = {31'h0, a < b_sh};
            SUB:     result_d = a - b_sh;
            default: result_d = a + b_sh;  // ADD
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_result <= '0;
        end else if (alu_go) begin
            alu_result <= result_d;
        end
    end

endmodule

// File: design/limn_cpu.sv
`timescale 1ns/100ps

module limn_cpu #(
    parameter limn_pkg::word_t RESET_VECTOR = 32'hFFFE0000
) (
    input  logic            clk,
    input  logic            rst,
    output limn_pkg::word_t addr,
    input  limn_pkg::word_t data_in,
    output limn_pkg::word_t data_out,
    input  logic            rdy,
    output logic            we,
    output logic            cs
);
    import limn_pkg::*;

    logic     alu_go;
    alu_req_t alu_req;
    word_t    alu_result;
    logic     lsu_go;
    lsu_req_t lsu_req;
    logic     lsu_busy;
    bus_req_t lsu_bus;
    logic     lsu_done;
    logic     lsu_wr_en;
    reg_idx_t lsu_wr_idx;
    word_t    lsu_wr_data;
    bus_req_t bus;

    // Memory bus pins
    assign cs       = bus.cs;
    assign we       = bus.we;
    assign addr     = bus.addr;
    assign data_out = bus.wdata;

    limn_sequencer #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .data_in     (data_in),
        .alu_go      (alu_go),
        .alu_req     (alu_req),
        .alu_result  (alu_result),
        .lsu_go      (lsu_go),
        .lsu_req     (lsu_req),
        .lsu_busy    (lsu_busy),
        .lsu_bus     (lsu_bus),
        .lsu_done    (lsu_done),
        .lsu_wr_en   (lsu_wr_en),
        .lsu_wr_idx  (lsu_wr_idx),
        .lsu_wr_data (lsu_wr_data),
        .bus         (bus)
    );

    limn_alu u_alu (
        .clk        (clk),
        .rst        (rst),
        .alu_go     (alu_go),
        .alu_req    (alu_req),
        .alu_result (alu_result)
    );

    limn_lsu u_lsu (
        .clk         (clk),
        .rst         (rst),
        .lsu_go      (lsu_go),
        .lsu_req     (lsu_req),
        .rdy         (rdy),
        .data_in     (data_in),
        .lsu_busy    (lsu_busy),
        .lsu_bus     (lsu_bus),
        .lsu_done    (lsu_done),
        .lsu_wr_en   (lsu_wr_en),
        .lsu_wr_idx  (lsu_wr_idx),
        .lsu_wr_data (lsu_wr_data)
    );

endmodule

// File: design/limn_lsu.sv
`timescale 1ns/100ps

module limn_lsu (
    input  logic               clk,
    input  logic               rst,
    input  logic               lsu_go,
    input  limn_pkg::lsu_req_t lsu_req,
    input  logic               rdy,
    input  limn_pkg::word_t    data_in,
    output logic               lsu_busy,
    output limn_pkg::bus_req_t lsu_bus,
    output logic               lsu_done,
    output logic               lsu_wr_en,
    output limn_pkg::reg_idx_t lsu_wr_idx,
    output limn_pkg::word_t    lsu_wr_data
);
    import limn_pkg::*;

    lsu_state_e state;
    lsu_req_t   req_q;
    word_t      word_q;     // Read word, then the merged store word
    word_t      lane_mask;
    logic [4:0] lane_sh;
    logic       ack;        // Request completes this cycle

    // Lane position from size and low address bits
    always_comb begin
        case (req_q.size)
            BYTE: begin
                lane_sh   = {req_q.addr[1:0], 3'b000};
                lane_mask = 32'h0000_00FF << lane_sh;
            end
            INT: begin
                lane_sh   = {req_q.addr[1], 4'b0000};
                lane_mask = 32'h0000_FFFF << lane_sh;
            end
            default: begin
                // Whole word, address bits 1:0 ignored
                lane_sh   = '0;
                lane_mask = '1;
            end
        endcase
    end

    assign lsu_bus = '{
        cs:    (state == READ) || (state == WRITE),
        we:    (state == WRITE),
        addr:  {req_q.addr[31:2], 2'b00},
        wdata: word_q
    };

    assign ack      = lsu_bus.cs && rdy;
    assign lsu_busy = (state != IDLE);

    // Loads finish on the read, stores on the write
    assign lsu_done    = ack && ((state == WRITE) || !req_q.is_store);
    assign lsu_wr_en   = ack && (state == READ) && !req_q.is_store;
    assign lsu_wr_idx  = req_q.rd;
    assign lsu_wr_data = (data_in & lane_mask) >> lane_sh;  // Zero-extended lane

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (lsu_go) begin
                        state <= (lsu_req.is_store && lsu_req.size == LONG) ? WRITE : READ;
                    end
                end
                READ:    if (ack) state <= req_q.is_store ? MERGE : IDLE;
                MERGE:   state <= WRITE;
                WRITE:   if (ack) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && lsu_go) begin
            req_q  <= lsu_req;
            word_q <= lsu_req.wdata;  // Long stores write this as is
        end else if (state == READ && ack) begin
            word_q <= data_in;
        end else if (state == MERGE) begin
            word_q <= (word_q & ~lane_mask) | ((req_q.wdata << lane_sh) & lane_mask);
        end
    end

endmodule

// File: design/limn_pkg.sv
package limn_pkg;

    localparam int WORD_W = 32;
    localparam int REG_W  = 5;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_idx_t;

    ////////////////////////////////////////
    // Instruction field positions (LSB)
    localparam int F_RA     = 6;   // Also rd
    localparam int F_RB     = 11;
    localparam int F_RC     = 16;
    localparam int F_IMM16  = 16;
    localparam int F_IMM21  = 9;   // Bit 20 of the field is the sign
    localparam int F_IMM29  = 3;
    localparam int F_IMM5   = 27;
    localparam int F_SHAMT  = 21;  // Register group only
    localparam int F_ALU_OP = 26;
    localparam int F_SHMODE = 29;

    // Low six bits, don't-care bits matched by casez
    localparam logic [5:0] OPC_IMM_ALU = 6'b???100;
    localparam logic [5:0] OPC_REG_ALU = 6'b111001;
    localparam logic [5:0] OPC_LOAD    = 6'b1??011;
    localparam logic [5:0] OPC_STORE   = 6'b???010;
    localparam logic [5:0] OPC_J       = 6'b???110;
    localparam logic [5:0] OPC_JAL     = 6'b???111;
    localparam logic [5:0] OPC_BEQ     = 6'b111101;
    localparam logic [5:0] OPC_BNE     = 6'b110101;
    localparam logic [5:0] OPC_BLT     = 6'b101101;

    localparam reg_idx_t REG_LR = 5'd31;  // Link register for JAL

    ////////////////////////////////////////
    // Enums
    typedef enum logic [2:0] {
        LUI_NOR = 3'd0,  // LUI for immediates, NOR for registers
        OR      = 3'd1,
        XOR     = 3'd2,
        AND     = 3'd3,
        SLTS    = 3'd4,
        SLT     = 3'd5,
        SUB     = 3'd6,
        ADD     = 3'd7
    } alu_op_e;

    typedef enum logic [1:0] {LHS, RHS, ASH, ROR} shift_mode_e;
    typedef enum logic [1:0] {LONG = 2'b01, INT = 2'b10, BYTE = 2'b11} mem_size_e;
    typedef enum logic [1:0] {FETCH, EXEC, ALU_WB, MEM_WAIT} seq_state_e;
    typedef enum logic [1:0] {IDLE, READ, MERGE, WRITE} lsu_state_e;

    ////////////////////////////////////////
    // Structs
    typedef struct packed {
        alu_op_e     op;
        logic        imm_mode;   // Immediate group instruction
        shift_mode_e shift_mode;
        logic [4:0]  shift_amt;
        word_t       a;
        word_t       b;
    } alu_req_t;

    typedef struct packed {
        logic      is_store;
        mem_size_e size;
        word_t     addr;
        word_t     wdata;
        reg_idx_t  rd;
    } lsu_req_t;

    typedef struct packed {
        logic  cs;
        logic  we;
        word_t addr;
        word_t wdata;
    } bus_req_t;

endpackage

// File: design/limn_regfile.sv
`timescale 1ns/100ps

module limn_regfile (
    input  logic               clk,
    input  limn_pkg::reg_idx_t rd_idx_a,
    input  limn_pkg::reg_idx_t rd_idx_b,
    output limn_pkg::word_t    rd_data_a,
    output limn_pkg::word_t    rd_data_b,
    input  logic               wr_en,
    input  limn_pkg::reg_idx_t wr_idx,
    input  limn_pkg::word_t    wr_data
);
    import limn_pkg::*;

    word_t regs [32];

    // Register 0 always reads as zero
    assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
    assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

    always_ff @(posedge clk) begin
        if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

// File: design/limn_sequencer.sv
`timescale 1ns/100ps

module limn_sequencer #(
    parameter limn_pkg::word_t RESET_VECTOR = 32'hFFFE0000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  limn_pkg::word_t    data_in,
    output logic               alu_go,
    output limn_pkg::alu_req_t alu_req,
    input  limn_pkg::word_t    alu_result,
    output logic               lsu_go,
    output limn_pkg::lsu_req_t lsu_req,
    input  logic               lsu_busy,
    input  limn_pkg::bus_req_t lsu_bus,
    input  logic               lsu_done,
    input  logic               lsu_wr_en,
    input  limn_pkg::reg_idx_t lsu_wr_idx,
    input  limn_pkg::word_t    lsu_wr_data,
    output limn_pkg::bus_req_t bus
);
    import limn_pkg::*;

    typedef enum logic [3:0] {
        C_NONE, C_BEQ, C_BNE, C_BLT, C_REG_ALU, C_IMM_ALU, C_LOAD, C_STORE, C_J, C_JAL
    } insn_class_e;

    seq_state_e  state;
    word_t       pc;
    word_t       ir;
    logic        running;    // Low in the first cycle after reset
    word_t       insn;
    insn_class_e cls;
    reg_idx_t    rf_idx_a;
    word_t       rf_a;
    word_t       rf_b;
    logic        rf_we;
    reg_idx_t    rf_widx;
    word_t       rf_wdata;
    bus_req_t    fetch_bus;
    logic        fetch_ack;
    word_t       pc_next;
    word_t       br_off;
    logic        br_taken;
    logic        is_alu;
    logic        is_lui;

    ////////////////////////////////////////
    // Decode

    // Bus word while fetching so the ALU starts in the rdy cycle
    assign insn = (state == FETCH) ? data_in : ir;

    always_comb begin
        casez (insn[5:0])
            OPC_BEQ:     cls = C_BEQ;
            OPC_BNE:     cls = C_BNE;
            OPC_BLT:     cls = C_BLT;
            OPC_REG_ALU: cls = C_REG_ALU;
            OPC_IMM_ALU: cls = C_IMM_ALU;
            OPC_LOAD:    cls = C_LOAD;
            OPC_STORE:   cls = C_STORE;
            OPC_J:       cls = C_J;
            OPC_JAL:     cls = C_JAL;
            default:     cls = C_NONE;
        endcase
    end

    assign rf_idx_a = (cls == C_REG_ALU) ? insn[F_RC +: REG_W] : insn[F_RA +: REG_W];

    limn_regfile u_regfile (
        .clk       (clk),
        .rd_idx_a  (rf_idx_a),
        .rd_idx_b  (insn[F_RB +: REG_W]),
        .rd_data_a (rf_a),
        .rd_data_b (rf_b),
        .wr_en     (rf_we),
        .wr_idx    (rf_widx),
        .wr_data   (rf_wdata)
    );

    ////////////////////////////////////////
    // ALU and load/store requests
    assign is_alu = (cls == C_REG_ALU) || (cls == C_IMM_ALU);

    assign alu_req = '{
        op:         alu_op_e'((cls == C_REG_ALU) ? insn[F_ALU_OP +: 3] : insn[5:3]),
        imm_mode:   (cls != C_REG_ALU),
        shift_mode: shift_mode_e'(insn[F_SHMODE +: 2]),
        shift_amt:  insn[F_SHAMT +: 5],
        a:          rf_b,
        b:          (cls == C_REG_ALU) ? rf_a : {16'h0, insn[F_IMM16 +: 16]}
    };
    assign alu_go = fetch_ack && is_alu;
    assign is_lui = (cls == C_IMM_ALU) && (alu_req.op == LUI_NOR);

    // Stores take the base from the rd field and data from rb or imm5
    assign lsu_req = '{
        is_store: (cls == C_STORE),
        size:     mem_size_e'(insn[4:3]),
        addr:     ((cls == C_STORE) ? rf_a : rf_b) + {16'h0, insn[F_IMM16 +: 16]},
        wdata:    insn[5] ? rf_b : {27'h0, insn[F_IMM5 +: 5]},
        rd:       insn[F_RA +: REG_W]
    };
    assign lsu_go = (state == EXEC) && ((cls == C_LOAD) || (cls == C_STORE));

    ////////////////////////////////////////
    // Branches and writeback
    assign pc_next = pc + 32'd4;
    assign br_off  = {10'h0, insn[F_IMM21 +: 20], 2'b00};  // Word magnitude

    always_comb begin
        case (cls)
            C_BEQ:   br_taken = (rf_a == '0);
            C_BNE:   br_taken = (rf_a != '0);
            C_BLT:   br_taken = rf_a[31];
            default: br_taken = 1'b0;
        endcase
    end

    always_comb begin
        rf_we    = 1'b0;
        rf_widx  = insn[F_RA +: REG_W];
        rf_wdata = alu_result;
        if (lsu_wr_en) begin
            rf_we    = 1'b1;
            rf_widx  = lsu_wr_idx;
            rf_wdata = lsu_wr_data;
        end else if (state == ALU_WB || (state == EXEC && is_lui)) begin
            rf_we = 1'b1;
        end else if (state == EXEC && cls == C_JAL) begin
            rf_we    = 1'b1;
            rf_widx  = REG_LR;
            rf_wdata = pc_next;
        end
    end

    // Load/store unit owns the bus while busy
    assign fetch_bus = '{cs: running && (state == FETCH), we: 1'b0, addr: pc, wdata: '0};
    assign fetch_ack = fetch_bus.cs && rdy;
    assign bus       = lsu_busy ? lsu_bus : fetch_bus;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= FETCH;
            pc      <= RESET_VECTOR;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            case (state)
                FETCH: if (fetch_ack) state <= EXEC;
                EXEC: begin
                    pc    <= pc_next;
                    state <= FETCH;
                    if (br_taken) begin
                        pc <= insn[F_IMM21 + 20] ? pc - br_off : pc + br_off;
                    end
                    if (cls == C_J || cls == C_JAL) begin
                        pc <= {pc[31], insn[F_IMM29 +: 29], 2'b00};  // Keeps the top bit
                    end
                    if (is_alu && !is_lui) state <= ALU_WB;
                    if (lsu_go) state <= MEM_WAIT;
                end
                ALU_WB:   state <= FETCH;
                MEM_WAIT: if (lsu_done) state <= FETCH;
                default:  state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_ack) begin
            ir <= data_in;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module limn_tb -f vlog.f -o Vlimn_tb
./obj_dir/Vlimn_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: verification/limn_bus_checker.sv
`timescale 1ns/100ps

module limn_bus_checker (
    input logic            clk,
    input logic            rst,
    input logic            cs,
    input logic            we,
    input logic            rdy,
    input limn_pkg::word_t addr,
    input limn_pkg::word_t data_out
);

    int fail_count = 0;   // Assertion failures so far

    // Pending request holds until rdy
    property request_holds;
        @(posedge clk) disable iff (rst)
            (cs && !rdy) |=> (cs && $stable(addr) && $stable(we) && $stable(data_out));
    endproperty

    property quiet_in_reset;
        @(posedge clk) (rst && $past(rst)) |-> (!cs && !we);
    endproperty

    assert property (request_holds) else begin
        fail_count++;
        $error("bus request changed while rdy was low");
    end

    assert property (quiet_in_reset) else begin
        fail_count++;
        $error("cs or we high during reset");
    end

endmodule

// File: verification/limn_scoreboard.sv
`timescale 1ns/100ps

module limn_scoreboard (
    input logic            clk,
    input logic            rst,
    input logic            cs,
    input logic            we,
    input logic            rdy,
    input limn_pkg::word_t addr,
    input limn_pkg::word_t data_out
);
    import limn_pkg::*;

    int   idx          = 0;
    int   err_total    = 0;
    int   reset_errors = 0;
    int   checked [5]  = '{default: 0};
    int   errors  [5]  = '{default: 0};
    logic done         = 1'b0;
    logic rst_q        = 1'b0;   // Reset already seen on an earlier edge

    task automatic report();
        int bus_errors;
        bus_errors = limn_tb.u_dut.u_bus_checker.fail_count;
        $display("reset: %0d errors", reset_errors);
        $display("control flow: %0d fetches, %0d errors", checked[0], errors[0]);
        $display("loads: %0d reads, %0d errors", checked[1], errors[1]);
        $display("stores: %0d transactions, %0d errors", checked[2] + checked[3],
                 errors[2] + errors[3]);
        $display("register dump: %0d writes, %0d errors", checked[4], errors[4]);
        $display("back-pressure: %0d assertion failures", bus_errors);
        err_total = reset_errors + bus_errors;
        for (int k = 0; k < 5; k++) err_total += errors[k];
        $display("Summary: %0d transactions, %0d errors", idx, err_total);
    endtask

    task automatic check_txn();
        logic [2:0] k;
        word_t      ea;
        word_t      ed;
        logic       bad;
        k   = limn_tb.exp_kind[idx];
        ea  = limn_tb.exp_addr[idx];
        ed  = limn_tb.exp_data[idx];
        bad = 1'b0;
        checked[k]++;
        if (addr !== ea) begin
            $display("Fail at %0t: addr = %h, expected %h", $time, addr, ea);
            bad = 1'b1;
        end
        if (we !== (k >= 3'd3)) begin
            $display("Fail at %0t: we = %b, expected %b", $time, we, k >= 3'd3);
            bad = 1'b1;
        end else if (we && data_out !== ed) begin
            $display("Fail at %0t: data_out = %h, expected %h", $time, data_out, ed);
            bad = 1'b1;
        end
        if (bad) errors[k]++;
        idx++;
        if (idx >= limn_tb.exp_n) begin
            done = 1'b1;
            report();
        end
    endtask

    always @(posedge clk) begin
        rst_q <= rst;
        if (rst) begin
            if (rst_q && (cs || we)) begin
                $display("Fail at %0t: cs = %b, expected 0 (we = %b) in reset", $time, cs, we);
                reset_errors++;
            end
        end else if (cs && rdy && !done) begin
            check_txn();
        end
    end

endmodule

// File: verification/limn_tb.sv
`timescale 1ns/100ps

module limn_tb;
    import limn_pkg::*;

    localparam int MEM_WORDS = 1024;
    localparam int MAX_TXN   = 2048;
    localparam int TIMEOUT   = 20000;   // Cycles after reset
    localparam int PROG_END  = 201;     // First word after the random part

    logic  clk;
    logic  rst;
    logic  rdy;
    word_t addr;
    word_t data_in;
    word_t data_out;
    logic  we;
    logic  cs;

    word_t image [MEM_WORDS];   // Program and data as loaded at reset
    word_t mem   [MEM_WORDS];

    // Expected bus transactions in order
    // Kind 0 fetch, 1 load read, 2 store read, 3 store write, 4 register dump write
    logic [2:0] exp_kind [MAX_TXN];
    word_t      exp_addr [MAX_TXN];
    word_t      exp_data [MAX_TXN];
    int         exp_n = 0;

    limn_cpu #(
        .RESET_VECTOR (32'h0000_0000)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out),
        .rdy      (rdy),
        .we       (we),
        .cs       (cs)
    );

    limn_scoreboard u_scoreboard (
        .clk      (clk),
        .rst      (rst),
        .cs       (cs),
        .we       (we),
        .rdy      (rdy),
        .addr     (addr),
        .data_out (data_out)
    );

    bind limn_cpu limn_bus_checker u_bus_checker (
        .clk      (clk),
        .rst      (rst),
        .cs       (cs),
        .we       (we),
        .rdy      (rdy),
        .addr     (addr),
        .data_out (data_out)
    );

    ////////////////////////////////////////
    // Clock, rdy and memory
    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        #1;
        rdy <= ($urandom % 3) != 0;   // Low one time in three
    end

    assign data_in = mem[addr[11:2]];

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= image[i];
            end
        end else if (cs && we && rdy) begin
            mem[addr[11:2]] <= data_out;
        end
    end

    ////////////////////////////////////////
    // Program generator
    task automatic build_program();
        int unsigned kind;
        int unsigned lim;
        word_t       imm;
        word_t       tgt;
        word_t       sz;
        logic [5:0]  opc;
        for (int w = 0; w < MEM_WORDS; w++) begin
            image[w] = (w >= 512) ? $urandom : word_t'(w) * 32'h9E37_79B9;
        end
        for (int w = 0; w < PROG_END; w++) begin
            kind = $urandom % 8;
            lim  = (PROG_END - w < 4) ? PROG_END - w : 4;  // Stay inside the random part
            sz   = 1 + $urandom % 3;
            case (kind)
                0, 1: image[w] = {16'($urandom), 5'($urandom), 5'($urandom),
                                  3'($urandom), 3'b100};
                2, 3: image[w] = {1'b0, 2'($urandom), 3'($urandom), 5'($urandom),
                                  5'($urandom), 5'($urandom), 5'($urandom), 6'b111001};
                4: begin
                    imm      = 32'h800 + $urandom % 32'h800;
                    image[w] = {imm[15:0], 5'd0, 5'($urandom), 1'b1, sz[1:0], 3'b011};
                end
                5: begin
                    tgt = 1 + $urandom % lim;   // Forward word magnitude
                    case ($urandom % 3)
                        0:       opc = OPC_BEQ;
                        1:       opc = OPC_BNE;
                        default: opc = OPC_BLT;
                    endcase
                    image[w] = {3'b000, tgt[19:0], 3'($urandom), opc};
                end
                6: begin
                    tgt      = w + 1 + $urandom % lim;
                    image[w] = {tgt[28:0], 2'b11, 1'($urandom)};  // J or JAL
                end
                default: begin
                    imm      = 32'h800 + $urandom % 32'h700;   // Below the dump area
                    image[w] = {imm[15:0], 5'($urandom), 5'd0, 1'($urandom), sz[1:0], 3'b010};
                end
            endcase
        end
        // Dump r1..r31 as longs, then spin
        for (int r = 1; r < 32; r++) begin
            imm                 = 32'hF00 + word_t'(r) * 4;
            image[PROG_END-1+r] = {imm[15:0], 5'(r), 5'd0, 6'b101010};
        end
        tgt              = PROG_END + 31;
        image[tgt[9:0]]  = {tgt[28:0], 3'b110};
    endtask

    ////////////////////////////////////////
    // ISA model
    task automatic push_txn(input logic [2:0] kind, input word_t a, input word_t d);
        if (exp_n < MAX_TXN) begin
            exp_kind[exp_n] = (kind == 3'd3 && a[11:0] >= 12'hF00) ? 3'd4 : kind;
            exp_addr[exp_n] = {a[31:2], 2'b00};
            exp_data[exp_n] = d;
            exp_n++;
        end
    endtask

    function automatic word_t alu_ref(input logic [2:0] op, input logic imm_grp,
                                      input word_t a, input word_t b);
        case (op)
            3'd0:    return imm_grp ? (a | (b << 16)) : ~(a | b);   // LUI or NOR
            3'd1:    return a | b;
            3'd2:    return a ^ b;
            3'd3:    return a & b;
            3'd4:    return {31'h0, $signed(a) < $signed(b)};
            3'd5:    return {31'h0, a < b};
            3'd6:    return a - b;
            default: return a + b;
        endcase
    endfunction

    function automatic word_t shift_ref(input logic [1:0] mode, input word_t b,
                                        input logic [4:0] amt);
        case (mode)
            2'd0:    return b >> amt;
            2'd1:    return b << amt;
            default: return $signed(b) >>> amt;
        endcase
    endfunction

    task automatic run_model();
        word_t regs [32];
        word_t mm   [MEM_WORDS];
        word_t pc;
        word_t insn;
        word_t ea;
        word_t wd;
        word_t res;
        word_t mag;
        logic  taken;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < MEM_WORDS; i++) mm[i] = image[i];
        pc = '0;
        for (int step = 0; step < 4000; step++) begin
            insn = mm[pc[11:2]];
            push_txn(3'd0, pc, '0);
            if (insn[2:0] == 3'b110 && {pc[31], insn[31:3], 2'b00} == pc) break;
            res   = '0;
            taken = 1'b0;
            mag   = {10'h0, insn[28:9], 2'b00};
            casez (insn[5:0])
                OPC_BEQ: taken = (regs[insn[10:6]] == '0);
                OPC_BNE: taken = (regs[insn[10:6]] != '0);
                OPC_BLT: taken = regs[insn[10:6]][31];
                OPC_REG_ALU: res = alu_ref(insn[28:26], 1'b0, regs[insn[15:11]],
                                           shift_ref(insn[30:29], regs[insn[20:16]], insn[25:21]));
                OPC_IMM_ALU: res = alu_ref(insn[5:3], 1'b1, regs[insn[15:11]],
                                           {16'h0, insn[31:16]});
                OPC_LOAD: begin
                    ea = regs[insn[15:11]] + {16'h0, insn[31:16]};
                    push_txn(3'd1, ea, '0);
                    wd = mm[ea[11:2]];
                    case (insn[4:3])
                        2'b11:   res = {24'h0, wd[{ea[1:0], 3'b000} +: 8]};
                        2'b10:   res = ea[1] ? {16'h0, wd[31:16]} : {16'h0, wd[15:0]};
                        default: res = wd;
                    endcase
                end
                OPC_STORE: begin
                    ea  = regs[insn[10:6]] + {16'h0, insn[31:16]};
                    res = insn[5] ? regs[insn[15:11]] : {27'h0, insn[31:27]};
                    wd  = mm[ea[11:2]];
                    if (insn[4:3] != 2'b01) push_txn(3'd2, ea, '0);
                    case (insn[4:3])
                        2'b11:   wd[{ea[1:0], 3'b000} +: 8] = res[7:0];
                        2'b10:   wd[{ea[1], 4'b0000} +: 16] = res[15:0];
                        default: wd = res;
                    endcase
                    mm[ea[11:2]] = wd;
                    push_txn(3'd3, ea, wd);
                end
                default: ;
            endcase
            casez (insn[5:0])
                OPC_BEQ, OPC_BNE, OPC_BLT: pc = taken ? (insn[29] ? pc - mag : pc + mag) : pc + 4;
                OPC_REG_ALU, OPC_IMM_ALU, OPC_LOAD: begin
                    if (insn[10:6] != 5'd0) regs[insn[10:6]] = res;
                    pc = pc + 4;
                end
                OPC_J, OPC_JAL: begin
                    if (insn[0]) regs[31] = pc + 4;   // Link
                    pc = {pc[31], insn[31:3], 2'b00};
                end
                default: pc = pc + 4;
            endcase
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        int cyc;
        void'($urandom(32'hddbe));
        rst = 1'b1;
        rdy = 1'b0;
        build_program();
        run_model();
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        cyc = 0;
        while (!u_scoreboard.done && cyc < TIMEOUT) begin
            @(posedge clk);
            cyc++;
        end
        if (!u_scoreboard.done) begin
            $display("Timeout: bus went quiet after %0d of %0d expected transactions",
                     u_scoreboard.idx, exp_n);
            u_scoreboard.report();
        end
        if (u_scoreboard.done && u_scoreboard.err_total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/limn_pkg.sv
design/limn_regfile.sv
design/limn_alu.sv
design/limn_lsu.sv
design/limn_sequencer.sv
design/limn_cpu.sv
verification/limn_bus_checker.sv
verification/limn_scoreboard.sv
verification/limn_tb.sv
